// ==== bench/operand_stage_tb.sv ====
`timescale 1ns/10ps
`include "pipe_cfg.svh"

module operand_stage_tb;

    localparam int VALID_TIMEOUT = 8;
    localparam int RANDOM_CYCLES = 300;
    localparam pipe_pkg::fwd_src_t NO_SRC = '0;

    // one table row: inputs for a cycle plus the operands expected from it
    typedef struct packed {
        pipe_pkg::rd_req_t       req;
        pipe_pkg::fwd_src_t      ex;
        pipe_pkg::fwd_src_t      ls;
        pipe_pkg::fwd_src_t      wb;
        logic                    stall_n;
        logic                    adv;
        pipe_pkg::operand_pair_t exp;
    } stim_row_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    pipe_pkg::rd_req_t       rd_req;
    pipe_pkg::fwd_src_t      ex_src;
    pipe_pkg::fwd_src_t      ls_src;
    pipe_pkg::fwd_src_t      wb_src;
    logic                    wb_stall_n;
    logic                    id_advance;
    pipe_pkg::operand_pair_t ex_operands;
    logic                    ex_operands_valid;

    stim_row_t               table_rows[$];
    pipe_pkg::xlen_t         shadow_regs [`REG_COUNT];
    pipe_pkg::fwd_src_t      shadow_hold;
    pipe_pkg::operand_pair_t last_ops;   // what EX should still hold
    logic [31:0]             rng_state = 32'ha955_666a;

    operand_stage dut_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .rd_req            (rd_req),
        .ex_src            (ex_src),
        .ls_src            (ls_src),
        .wb_src            (wb_src),
        .wb_stall_n        (wb_stall_n),
        .id_advance        (id_advance),
        .ex_operands       (ex_operands),
        .ex_operands_valid (ex_operands_valid)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic pipe_pkg::fwd_src_t stage_src(
        input logic               wen,
        input pipe_pkg::reg_idx_t rd,
        input pipe_pkg::xlen_t    data
    );
        pipe_pkg::fwd_src_t s;
        s.wen  = wen;
        s.rd   = rd;
        s.data = data;
        return s;
    endfunction

    task automatic add_row(
        input pipe_pkg::reg_idx_t rs1,
        input pipe_pkg::reg_idx_t rs2,
        input pipe_pkg::fwd_src_t ex,
        input pipe_pkg::fwd_src_t ls,
        input pipe_pkg::fwd_src_t wb,
        input logic               stall_n,
        input logic               adv,
        input pipe_pkg::xlen_t    exp1,
        input pipe_pkg::xlen_t    exp2
    );
        stim_row_t r;
        r.req.rs1 = rs1;
        r.req.rs2 = rs2;
        r.ex      = ex;
        r.ls      = ls;
        r.wb      = wb;
        r.stall_n = stall_n;
        r.adv     = adv;
        r.exp.op1 = exp1;
        r.exp.op2 = exp2;
        table_rows.push_back(r);
    endtask

    task automatic build_table();
        // args: rs1, rs2, ex, ls, wb, wb_stall_n, id_advance, op1, op2
        add_row(5'd0, 5'd0, NO_SRC, NO_SRC, stage_src(1'b1, 5'd1, 32'h1111_0001),
                1'b1, 1'b0, '0, '0);
        add_row(5'd0, 5'd0, NO_SRC, NO_SRC, stage_src(1'b1, 5'd2, 32'h2222_0002),
                1'b1, 1'b0, '0, '0);
        add_row(5'd0, 5'd0, NO_SRC, NO_SRC, stage_src(1'b1, 5'd3, 32'h3333_0003),
                1'b1, 1'b0, '0, '0);
        add_row(5'd0, 5'd0, NO_SRC, NO_SRC, stage_src(1'b1, 5'd4, 32'h4444_0004),
                1'b1, 1'b0, '0, '0);
        add_row(5'd1, 5'd2, NO_SRC, NO_SRC, NO_SRC, 1'b1, 1'b1, 32'h1111_0001, 32'h2222_0002);
        add_row(5'd3, 5'd4, NO_SRC, NO_SRC, NO_SRC, 1'b1, 1'b1, 32'h3333_0003, 32'h4444_0004);
        add_row(5'd0, 5'd0, NO_SRC, NO_SRC, stage_src(1'b1, 5'd5, 32'h5555_0005),
                1'b1, 1'b0, '0, '0);
        add_row(5'd5, 5'd1, NO_SRC, NO_SRC, NO_SRC, 1'b1, 1'b1, 32'h5555_0005, 32'h1111_0001);
        add_row(5'd0, 5'd0, NO_SRC, NO_SRC, stage_src(1'b1, 5'd6, 32'h6666_0006),
                1'b1, 1'b0, '0, '0);
        // all three sources aim at x6
        add_row(5'd6, 5'd6, stage_src(1'b1, 5'd6, 32'heeee_0006),
                stage_src(1'b1, 5'd6, 32'hdddd_0006), NO_SRC, 1'b1, 1'b1,
                32'heeee_0006, 32'heeee_0006);
        add_row(5'd6, 5'd5, NO_SRC, stage_src(1'b1, 5'd6, 32'hdddd_0006), NO_SRC,
                1'b1, 1'b1, 32'hdddd_0006, 32'h5555_0005);
        add_row(5'd6, 5'd2, stage_src(1'b0, 5'd6, 32'hbad0_bad0),
                stage_src(1'b0, 5'd6, 32'hbad1_bad1), NO_SRC, 1'b1, 1'b1,
                32'h6666_0006, 32'h2222_0002);
        // x0 targeted by everyone
        add_row(5'd0, 5'd0, stage_src(1'b1, 5'd0, 32'haaaa_aaaa),
                stage_src(1'b1, 5'd0, 32'hbbbb_bbbb), stage_src(1'b1, 5'd0, 32'hcccc_cccc),
                1'b1, 1'b1, '0, '0);
        add_row(5'd0, 5'd0, NO_SRC, NO_SRC, NO_SRC, 1'b1, 1'b1, '0, '0);
        add_row(5'd0, 5'd0, NO_SRC, NO_SRC, stage_src(1'b1, 5'd7, 32'h7777_0007),
                1'b1, 1'b0, '0, '0);
        add_row(5'd0, 5'd0, NO_SRC, NO_SRC, stage_src(1'b1, 5'd7, 32'hdead_0007),
                1'b0, 1'b0, '0, '0);
        add_row(5'd7, 5'd8, NO_SRC, NO_SRC, stage_src(1'b1, 5'd8, 32'hbeef_0008),
                1'b0, 1'b1, 32'h7777_0007, '0);
        add_row(5'd7, 5'd8, NO_SRC, NO_SRC, NO_SRC, 1'b1, 1'b1, 32'h7777_0007, '0);
        // EX must keep its operands while ID holds back
        add_row(5'd1, 5'd2, stage_src(1'b1, 5'd1, 32'h1234_5678), NO_SRC, NO_SRC,
                1'b1, 1'b0, '0, '0);
        add_row(5'd3, 5'd4, NO_SRC, NO_SRC, NO_SRC, 1'b1, 1'b0, '0, '0);
        add_row(5'd3, 5'd4, NO_SRC, NO_SRC, NO_SRC, 1'b1, 1'b1, 32'h3333_0003, 32'h4444_0004);
    endtask

    function automatic stim_row_t random_row();
        logic [31:0] ctl;
        stim_row_t   r;
        ctl       = next_rand();   // upper bits only, low LCG bits are weak
        r.req.rs1 = pipe_pkg::reg_idx_t'(ctl[31:29]);
        r.req.rs2 = pipe_pkg::reg_idx_t'(ctl[28:26]);
        r.ex      = stage_src(ctl[25], pipe_pkg::reg_idx_t'(ctl[24:22]), next_rand());
        r.ls      = stage_src(ctl[21], pipe_pkg::reg_idx_t'(ctl[20:18]), next_rand());
        r.wb      = stage_src(ctl[17], pipe_pkg::reg_idx_t'(ctl[16:14]), next_rand());
        r.stall_n = (ctl[13:10] != 4'd0);
        r.adv     = (ctl[9:8] != 2'd0);
        r.exp     = '0;
        return r;
    endfunction

    function automatic pipe_pkg::xlen_t model_operand(
        input pipe_pkg::reg_idx_t rs,
        input pipe_pkg::fwd_src_t ex,
        input pipe_pkg::fwd_src_t ls
    );
        if (rs == '0)
            return '0;
        if (ex.wen && (ex.rd == rs))
            return ex.data;
        if (ls.wen && (ls.rd == rs))
            return ls.data;
        if (shadow_hold.wen && (shadow_hold.rd == rs))
            return shadow_hold.data;
        return shadow_regs[rs];
    endfunction

    task automatic shadow_edge(input stim_row_t r);
        if (shadow_hold.wen && (shadow_hold.rd != '0)) begin
            shadow_regs[shadow_hold.rd] = shadow_hold.data;   // old hold copy first
        end
        if (r.wb.wen && r.stall_n) begin
            shadow_hold = r.wb;
        end
    endtask

    task automatic drive_inputs(input stim_row_t r);
        rd_req     = r.req;
        ex_src     = r.ex;
        ls_src     = r.ls;
        wb_src     = r.wb;
        wb_stall_n = r.stall_n;
        id_advance = r.adv;
    endtask

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_mismatch(
        input string           name,
        input pipe_pkg::xlen_t expected,
        input pipe_pkg::xlen_t actual
    );
        $display("Fail %s expected 0x%h actual 0x%h", name, expected, actual);
        stop_run();
    endtask

    task automatic plain_error(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic apply_row(input stim_row_t r, input logic directed);
        pipe_pkg::operand_pair_t expect_ops;
        int                      waited;
        drive_inputs(r);
        if (directed) begin
            expect_ops = r.exp;
        end else begin
            expect_ops.op1 = model_operand(r.req.rs1, r.ex, r.ls);
            expect_ops.op2 = model_operand(r.req.rs2, r.ex, r.ls);
        end
        @(posedge clk);
        shadow_edge(r);
        #1;
        if (r.adv) begin
            waited = 0;
            while (!ex_operands_valid && (waited < VALID_TIMEOUT)) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (!ex_operands_valid) begin
                plain_error("ex_operands_valid never rose after id_advance was set");
            end else begin
                assert (ex_operands.op1 == expect_ops.op1)
                    else value_mismatch("ex_operands.op1", expect_ops.op1, ex_operands.op1);
                assert (ex_operands.op2 == expect_ops.op2)
                    else value_mismatch("ex_operands.op2", expect_ops.op2, ex_operands.op2);
                last_ops = expect_ops;
            end
        end else begin
            assert (!ex_operands_valid)
                else value_mismatch("ex_operands_valid", '0,
                                    pipe_pkg::xlen_t'(ex_operands_valid));
            assert (ex_operands.op1 == last_ops.op1)
                else value_mismatch("ex_operands.op1", last_ops.op1, ex_operands.op1);
            assert (ex_operands.op2 == last_ops.op2)
                else value_mismatch("ex_operands.op2", last_ops.op2, ex_operands.op2);
        end
    endtask

    initial begin
        stim_row_t idle;
        idle         = '0;
        idle.stall_n = 1'b1;
        rst_n        = 1'b0;
        drive_inputs(idle);
        for (int i = 0; i < `REG_COUNT; i++) begin
            shadow_regs[i] = '0;
        end
        shadow_hold = '0;
        last_ops    = '0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (table_rows[i]) begin
            apply_row(table_rows[i], 1'b1);
        end
        repeat (RANDOM_CYCLES) begin
            apply_row(random_row(), 1'b0);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+source
source/pipe_pkg.sv
source/forwarding.sv
source/reg_file.sv
source/operand_select.sv
source/operand_stage.sv
bench/operand_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f flist.f --top-module operand_stage_tb \
    -o operand_stage_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/operand_stage_sim > sim.log 2>&1 \
    || echo "simulator exited with an error"

grep -qx "TEST PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== source/forwarding.sv ====
`timescale 1ns/10ps
`include "pipe_cfg.svh"

module forwarding (
    input  logic                clk,
    input  logic                rst_n,
    input  pipe_pkg::rd_req_t   rd_req,
    input  pipe_pkg::fwd_src_t  ex_src,
    input  pipe_pkg::fwd_src_t  ls_src,
    input  pipe_pkg::fwd_src_t  wb_src,
    input  logic                wb_stall_n,
    output pipe_pkg::fwd_sel_e  rs1_sel,
    output pipe_pkg::fwd_sel_e  rs2_sel,
    output pipe_pkg::fwd_src_t  wb_hold
);

    // a source hits when it writes a nonzero rd equal to the operand index
    function automatic logic src_hit(
        input pipe_pkg::fwd_src_t src,
        input pipe_pkg::reg_idx_t rs
    );
        return src.wen && (src.rd == rs) && (|src.rd);
    endfunction

    function automatic pipe_pkg::fwd_sel_e pick_src(
        input pipe_pkg::reg_idx_t rs,
        input pipe_pkg::fwd_src_t ex,
        input pipe_pkg::fwd_src_t ls,
        input pipe_pkg::fwd_src_t hold
    );
        if (src_hit(ex, rs)) begin             // youngest result wins
            return pipe_pkg::SEL_EX;
        end else if (src_hit(ls, rs)) begin
            return pipe_pkg::SEL_LS;
        end else if (src_hit(hold, rs)) begin
            return pipe_pkg::SEL_WB;
        end
        return pipe_pkg::SEL_RF;
    endfunction

    // hold copy of the last accepted writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_hold <= '0;
        end else if (wb_src.wen && wb_stall_n) begin   // stalled writeback is dropped
            wb_hold <= wb_src;
        end
    end

    assign rs1_sel = pick_src(rd_req.rs1, ex_src, ls_src, wb_hold);
    assign rs2_sel = pick_src(rd_req.rs2, ex_src, ls_src, wb_hold);

    // x0 must always come from the register file
    x0_not_forwarded: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((rd_req.rs1 == '0) |-> (rs1_sel == pipe_pkg::SEL_RF)) and
        ((rd_req.rs2 == '0) |-> (rs2_sel == pipe_pkg::SEL_RF))
    );

endmodule

// ==== source/operand_select.sv ====
`timescale 1ns/10ps
`include "pipe_cfg.svh"

module operand_select (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    id_advance,
    input  pipe_pkg::fwd_sel_e      rs1_sel,
    input  pipe_pkg::fwd_sel_e      rs2_sel,
    input  pipe_pkg::operand_pair_t rf_data,
    input  pipe_pkg::fwd_src_t      ex_src,
    input  pipe_pkg::fwd_src_t      ls_src,
    input  pipe_pkg::fwd_src_t      wb_hold,
    output pipe_pkg::operand_pair_t ex_operands,
    output logic                    ex_operands_valid
);

    pipe_pkg::operand_pair_t op_next;

    function automatic pipe_pkg::xlen_t steer(
        input pipe_pkg::fwd_sel_e sel,
        input pipe_pkg::xlen_t    rf_word,
        input pipe_pkg::xlen_t    ex_word,
        input pipe_pkg::xlen_t    ls_word,
        input pipe_pkg::xlen_t    wb_word
    );
        case (sel)
            pipe_pkg::SEL_EX: return ex_word;
            pipe_pkg::SEL_LS: return ls_word;
            pipe_pkg::SEL_WB: return wb_word;
            default:          return rf_word;
        endcase
    endfunction

    always_comb begin
        op_next.op1 = steer(rs1_sel, rf_data.op1, ex_src.data, ls_src.data, wb_hold.data);
        op_next.op2 = steer(rs2_sel, rf_data.op2, ex_src.data, ls_src.data, wb_hold.data);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_operands       <= '0;
            ex_operands_valid <= 1'b0;
        end else begin
            ex_operands_valid <= id_advance;
            if (id_advance) begin
                ex_operands <= op_next;   // otherwise EX keeps its operands
            end
        end
    end

    // no fresh operands without a handoff from ID
    no_valid_without_advance: assert property (
        @(posedge clk) disable iff (!rst_n)
        !id_advance |=> (!ex_operands_valid && $stable(ex_operands))
    );

endmodule

// ==== source/operand_stage.sv ====
`timescale 1ns/10ps
`include "pipe_cfg.svh"

module operand_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pipe_pkg::rd_req_t       rd_req,
    input  pipe_pkg::fwd_src_t      ex_src,
    input  pipe_pkg::fwd_src_t      ls_src,
    input  pipe_pkg::fwd_src_t      wb_src,
    input  logic                    wb_stall_n,
    input  logic                    id_advance,
    output pipe_pkg::operand_pair_t ex_operands,
    output logic                    ex_operands_valid
);

    pipe_pkg::fwd_sel_e      rs1_sel;
    pipe_pkg::fwd_sel_e      rs2_sel;
    pipe_pkg::fwd_src_t      wb_hold;   // also the register file write port
    pipe_pkg::operand_pair_t rf_data;

    forwarding forwarding_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_req     (rd_req),
        .ex_src     (ex_src),
        .ls_src     (ls_src),
        .wb_src     (wb_src),
        .wb_stall_n (wb_stall_n),
        .rs1_sel    (rs1_sel),
        .rs2_sel    (rs2_sel),
        .wb_hold    (wb_hold)
    );

    reg_file reg_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wb_hold),
        .rd_req  (rd_req),
        .rf_data (rf_data)
    );

    operand_select operand_select_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .id_advance        (id_advance),
        .rs1_sel           (rs1_sel),
        .rs2_sel           (rs2_sel),
        .rf_data           (rf_data),
        .ex_src            (ex_src),
        .ls_src            (ls_src),
        .wb_hold           (wb_hold),
        .ex_operands       (ex_operands),
        .ex_operands_valid (ex_operands_valid)
    );

endmodule

// ==== source/pipe_cfg.svh ====
`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

// datapath word width
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

// bits to index one register
`define REG_ADDR_WIDTH 5

`endif

// ==== source/pipe_pkg.sv ====
`include "pipe_cfg.svh"

package pipe_pkg;

    typedef logic [`XLEN-1:0]           xlen_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_idx_t;

    // one producing stage, or the writeback hold copy
    typedef struct packed {
        logic     wen;
        reg_idx_t rd;
        xlen_t    data;
    } fwd_src_t;

    // source indices named by ID
    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
    } rd_req_t;

    typedef struct packed {
        xlen_t op1;
        xlen_t op2;
    } operand_pair_t;

    // where an operand comes from
    typedef enum logic [1:0] {
        SEL_RF = 2'd0,
        SEL_EX = 2'd1,
        SEL_LS = 2'd2,
        SEL_WB = 2'd3
    } fwd_sel_e;

endpackage

// ==== source/reg_file.sv ====
`timescale 1ns/10ps
`include "pipe_cfg.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pipe_pkg::fwd_src_t      wr,
    input  pipe_pkg::rd_req_t       rd_req,
    output pipe_pkg::operand_pair_t rf_data
);

    pipe_pkg::xlen_t regs [`REG_COUNT];

    // written from the hold copy, one cycle after capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.wen && (wr.rd != '0)) begin   // x0 stays zero
            regs[wr.rd] <= wr.data;
        end
    end

    // two async read ports
    always_comb begin
        rf_data.op1 = regs[rd_req.rs1];
        rf_data.op2 = regs[rd_req.rs2];
    end

    // a write aimed at x0 must never leak into either read port
    x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((rd_req.rs1 == '0) |-> (rf_data.op1 == '0)) and
        ((rd_req.rs2 == '0) |-> (rf_data.op2 == '0))
    );

endmodule
